// File: Makefile
VERILATOR := verilator
TOP       := gsau_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

# build the testbench, then run it from the project root so the stimulus path resolves
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
hdl/gsau_pkg.sv
hdl/sync_fifo.sv
hdl/mac_pe.sv
hdl/systolic_array.sv
hdl/gsau_control_unit.sv
hdl/gsau_top.sv
test/gsau_asserts.sv
test/gsau_tb.sv

// File: hdl/gsau_control_unit.sv
`timescale 1ns/1ns

// scoreboard handshake, array strobes and in-order destination pairing
module gsau_control_unit import gsau_pkg::*; #(
  parameter int  VEGGIEREGS = 256,
  parameter int  VDST_DEPTH = 16,
  parameter type vdst_t     = logic [$clog2(VEGGIEREGS)-1:0]
) (
  input  logic      CLK,
  input  logic      rst_n,
  // scoreboard side
  input  logic      sb_valid,
  output logic      sb_ready,
  input  logic      sb_weight,   // 1 = weight row load, 0 = input op
  input  vdst_t     sb_vdst,
  // register file operands
  input  elem_vec_t veg_vdata1,
  input  psum_vec_t veg_vdata2,
  // array side
  output elem_vec_t sa_in,
  output psum_vec_t sa_partials,
  output logic      sa_weight_en,
  output logic      sa_input_en,
  input  logic      sa_has_space,
  input  logic      sa_out_valid,
  output logic      sa_out_ready,
  input  psum_vec_t sa_out,
  // writeback side
  input  logic      wb_ready,
  output logic      wb_valid,
  output vdst_t     wb_vdst,
  output psum_vec_t wb_psum
);

  typedef struct packed {
    logic  weight;
    vdst_t vdst;
  } sb_req_t;

  typedef struct packed {
    vdst_t     vdst;
    psum_vec_t psum;
  } wb_beat_t;

  sb_req_t  req;
  operand_t ops;
  wb_beat_t beat;
  logic     xfer;
  vdst_t    vdst_head;
  logic     vdst_empty;
  logic     vdst_full;

  assign req = '{weight: sb_weight, vdst: sb_vdst};
  assign ops = '{vdata1: veg_vdata1, vdata2: veg_vdata2};

  // open issue only when a destination slot, an array slot and writeback are all free
  assign sb_ready = !vdst_full && sa_has_space && wb_ready;
  assign xfer     = sb_valid && sb_ready;

  // operands go straight through, strobes qualify them
  assign sa_in        = ops.vdata1;
  assign sa_partials  = ops.vdata2;
  assign sa_weight_en = xfer && req.weight;
  assign sa_input_en  = xfer && !req.weight;  // also pushes the vdst

  // writeback fires only with both heads present
  assign sa_out_ready = wb_ready;
  assign wb_valid     = sa_out_valid && wb_ready && !vdst_empty;

  assign beat    = '{vdst: vdst_head, psum: sa_out};
  assign wb_vdst = beat.vdst;
  assign wb_psum = beat.psum;

  // destinations wait here in issue order, one per input op
  sync_fifo #(
    .entry_t(vdst_t),
    .DEPTH  (VDST_DEPTH)
  ) u_vdst_q (
    .CLK  (CLK),
    .rst_n(rst_n),
    .push (sa_input_en),
    .pop  (wb_valid),     // pops alongside the array output queue
    .din  (req.vdst),
    .dout (vdst_head),
    .count(),
    .empty(vdst_empty),
    .full (vdst_full)
  );

endmodule

// File: hdl/gsau_pkg.sv
// shared constants and vector types for the systolic array unit
package gsau_pkg;

  // array geometry
  localparam int ARRAY_N = 4;   // rows and columns of the mac grid
  localparam int DATA_W  = 8;   // weight / activation element, unsigned
  localparam int PSUM_W  = 16;  // partial sum element, wraps on overflow

  // accept-to-push latency of the array pipeline
  // row/column skew plus the pe registers plus the deskew tail
  localparam int sa_lat = ARRAY_N + 2;

  // one row of weights or one activation vector
  // element i sits at bits [i*DATA_W +: DATA_W]
  typedef logic [ARRAY_N-1:0][DATA_W-1:0] elem_vec_t;

  // one partial-sum vector, element c belongs to column c
  typedef logic [ARRAY_N-1:0][PSUM_W-1:0] psum_vec_t;

  // the two register file operands that ride along with a request
  // vdata1 is a weight row on a load, activations on an input
  // vdata2 only matters on an input
  typedef struct packed {
    elem_vec_t vdata1;
    psum_vec_t vdata2;
  } operand_t;

  // request and writeback structs carry the destination register,
  // whose width follows VEGGIEREGS, so they live in the modules

endpackage

// File: hdl/gsau_top.sv
`timescale 1ns/1ns

// gsau top: control unit in front of the systolic array
module gsau_top import gsau_pkg::*; #(
  parameter int VEGGIEREGS = 256,
  parameter int VDST_DEPTH = 16,
  parameter int OUT_DEPTH  = 8
) (
  input  logic                          CLK,
  input  logic                          rst_n,
  input  logic                          sb_valid,
  output logic                          sb_ready,
  input  logic                          sb_weight,
  input  logic [$clog2(VEGGIEREGS)-1:0] sb_vdst,
  input  elem_vec_t                     veg_vdata1,
  input  psum_vec_t                     veg_vdata2,
  input  logic                          wb_ready,
  output logic                          wb_valid,
  output logic [$clog2(VEGGIEREGS)-1:0] wb_vdst,
  output psum_vec_t                     wb_psum
);

  typedef logic [$clog2(VEGGIEREGS)-1:0] vdst_t;  // 8 bits at 256 regs

  elem_vec_t sa_in;
  psum_vec_t sa_partials;
  psum_vec_t sa_out;
  logic      sa_weight_en;
  logic      sa_input_en;
  logic      sa_has_space;
  logic      sa_out_valid;
  logic      sa_out_ready;

  gsau_control_unit #(
    .VEGGIEREGS(VEGGIEREGS),
    .VDST_DEPTH(VDST_DEPTH),
    .vdst_t    (vdst_t)
  ) u_ctrl (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .sb_valid    (sb_valid),
    .sb_ready    (sb_ready),
    .sb_weight   (sb_weight),
    .sb_vdst     (sb_vdst),
    .veg_vdata1  (veg_vdata1),
    .veg_vdata2  (veg_vdata2),
    .sa_in       (sa_in),
    .sa_partials (sa_partials),
    .sa_weight_en(sa_weight_en),
    .sa_input_en (sa_input_en),
    .sa_has_space(sa_has_space),
    .sa_out_valid(sa_out_valid),
    .sa_out_ready(sa_out_ready),
    .sa_out      (sa_out),
    .wb_ready    (wb_ready),
    .wb_valid    (wb_valid),
    .wb_vdst     (wb_vdst),
    .wb_psum     (wb_psum)
  );

  // output queue must cover the full pipe, so OUT_DEPTH >= in-flight max
  systolic_array #(
    .OUT_DEPTH(OUT_DEPTH)
  ) u_array (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .weight_en(sa_weight_en),
    .input_en (sa_input_en),
    .in_vec   (sa_in),
    .partials (sa_partials),
    .has_space(sa_has_space),
    .out_valid(sa_out_valid),
    .out_ready(sa_out_ready),
    .out_vec  (sa_out)
  );

endmodule

// File: hdl/mac_pe.sv
`timescale 1ns/1ns

// weight-stationary mac cell
// activation flows right, partial sum flows down, weight shifts down on load
module mac_pe import gsau_pkg::*; (
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              w_load,
  input  logic [DATA_W-1:0] w_in,
  output logic [DATA_W-1:0] w_out,
  input  logic [DATA_W-1:0] a_in,
  output logic [DATA_W-1:0] a_out,
  input  logic [PSUM_W-1:0] p_in,
  output logic [PSUM_W-1:0] p_out
);

  logic [DATA_W-1:0] weight_q;
  logic [PSUM_W-1:0] prod;

  // 8x8 unsigned product fits 16 bits exactly
  assign prod  = PSUM_W'(a_in) * PSUM_W'(weight_q);
  assign w_out = weight_q;  // old weight feeds the row below

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      weight_q <= '0;  // array starts with zero weights
    end else if (w_load) begin
      weight_q <= w_in;
    end
  end

  // one pipeline step per cycle
  always_ff @(posedge CLK) begin
    a_out <= a_in;
    p_out <= p_in + prod;  // wraps at PSUM_W
  end

endmodule

// File: hdl/sync_fifo.sv
`timescale 1ns/1ns

// circular buffer, head always on dout
module sync_fifo #(
  parameter type entry_t = logic,
  parameter int  DEPTH   = 4,
  parameter int  CNT_W   = $clog2(DEPTH + 1)  // count must reach DEPTH
) (
  input  logic             CLK,
  input  logic             rst_n,
  input  logic             push,
  input  logic             pop,
  input  entry_t           din,
  output entry_t           dout,
  output logic [CNT_W-1:0] count,
  output logic             empty,
  output logic             full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  entry_t           mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic             do_push;
  logic             do_pop;

  // wrap without needing a power-of-two depth
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));
  assign do_push = push && !full;   // overflow push dropped
  assign do_pop  = pop && !empty;   // underflow pop dropped
  assign dout    = mem[rd_ptr];     // show-ahead

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle, or push and pop cancel
      endcase
    end
  end

  // storage
  always_ff @(posedge CLK) begin
    if (do_push) mem[wr_ptr] <= din;
  end

endmodule

// File: hdl/systolic_array.sv
`timescale 1ns/1ns

// 4x4 weight-stationary grid
// activations enter on the left, skewed by row
// partials enter on top, skewed by column
// results leave the bottom, get deskewed and land in an output queue
module systolic_array import gsau_pkg::*; #(
  parameter int OUT_DEPTH = 8
) (
  input  logic      CLK,
  input  logic      rst_n,
  input  logic      weight_en,
  input  logic      input_en,
  input  elem_vec_t in_vec,
  input  psum_vec_t partials,
  output logic      has_space,
  output logic      out_valid,
  input  logic      out_ready,
  output psum_vec_t out_vec
);

  localparam int OCNT_W = $clog2(OUT_DEPTH + 1);
  localparam int FL_W   = $clog2(sa_lat + 2);
  localparam int OCC_W  = $clog2(OUT_DEPTH + sa_lat + 2);

  elem_vec_t         act_in;
  psum_vec_t         part_in;
  logic [DATA_W-1:0] a_h [ARRAY_N][ARRAY_N+1];  // horizontal activation links
  logic [DATA_W-1:0] w_v [ARRAY_N+1][ARRAY_N];  // vertical weight chain
  logic [PSUM_W-1:0] p_v [ARRAY_N+1][ARRAY_N];  // vertical partial links
  psum_vec_t         res_vec;                   // aligned result
  logic [sa_lat:0]   vld_q;                     // marks real results in the pipe
  logic [FL_W-1:0]   in_flight;
  logic [OCNT_W-1:0] q_count;
  logic              q_empty;
  logic [OCC_W-1:0]  occupancy;

  // keep idle cycles at zero so the grid only toggles on real work
  assign act_in  = input_en ? in_vec : '0;
  assign part_in = input_en ? partials : '0;

  // row r activation waits r cycles
  for (genvar r = 0; r < ARRAY_N; r++) begin : g_row
    if (r == 0) begin : g_direct
      assign a_h[0][0] = act_in[0];
    end else begin : g_skew
      logic [DATA_W-1:0] dly_q [r];
      always_ff @(posedge CLK) begin
        dly_q[0] <= act_in[r];
        for (int k = 1; k < r; k++) begin
          dly_q[k] <= dly_q[k-1];
        end
      end
      assign a_h[r][0] = dly_q[r-1];
    end
  end

  // column c: partial waits c cycles going in, result waits N-1-c coming out
  for (genvar c = 0; c < ARRAY_N; c++) begin : g_col
    assign w_v[0][c] = in_vec[c];  // new weight row enters row 0

    if (c == 0) begin : g_p_direct
      assign p_v[0][0] = part_in[0];
    end else begin : g_p_skew
      logic [PSUM_W-1:0] dly_q [c];
      always_ff @(posedge CLK) begin
        dly_q[0] <= part_in[c];
        for (int k = 1; k < c; k++) begin
          dly_q[k] <= dly_q[k-1];
        end
      end
      assign p_v[0][c] = dly_q[c-1];
    end

    if (c == ARRAY_N - 1) begin : g_o_direct
      assign res_vec[c] = p_v[ARRAY_N][c];  // last column is already latest
    end else begin : g_o_deskew
      logic [PSUM_W-1:0] dly_q [ARRAY_N-1-c];
      always_ff @(posedge CLK) begin
        dly_q[0] <= p_v[ARRAY_N][c];
        for (int k = 1; k < ARRAY_N - 1 - c; k++) begin
          dly_q[k] <= dly_q[k-1];
        end
      end
      assign res_vec[c] = dly_q[ARRAY_N-2-c];
    end
  end

  // the grid itself
  for (genvar r = 0; r < ARRAY_N; r++) begin : g_pe_row
    for (genvar c = 0; c < ARRAY_N; c++) begin : g_pe_col
      mac_pe u_pe (
        .CLK   (CLK),
        .rst_n (rst_n),
        .w_load(weight_en),  // whole grid shifts down together
        .w_in  (w_v[r][c]),
        .w_out (w_v[r+1][c]),
        .a_in  (a_h[r][c]),
        .a_out (a_h[r][c+1]),
        .p_in  (p_v[r][c]),
        .p_out (p_v[r+1][c])
      );
    end
  end

  // valid tag shadows the data through skew, grid and deskew
  // in_flight counts accepted inputs not yet pushed
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      vld_q     <= '0;
      in_flight <= '0;
    end else begin
      vld_q <= {vld_q[sa_lat-1:0], input_en};
      case ({input_en, vld_q[sa_lat]})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
    end
  end

  sync_fifo #(
    .entry_t(psum_vec_t),
    .DEPTH  (OUT_DEPTH)
  ) u_out_q (
    .CLK  (CLK),
    .rst_n(rst_n),
    .push (vld_q[sa_lat]),  // whole vector aligned this cycle
    .pop  (out_ready),      // ignored inside when empty
    .din  (res_vec),
    .dout (out_vec),
    .count(q_count),
    .empty(q_empty),
    .full ()
  );

  // reserve a queue slot for every result still in the pipe
  assign occupancy = OCC_W'(q_count) + OCC_W'(in_flight);
  assign has_space = occupancy < OCC_W'(OUT_DEPTH);
  assign out_valid = !q_empty;

endmodule

// File: test/gsau_asserts.sv
`timescale 1ns/1ns

// handshake and queue rules checked inside gsau_top
module gsau_asserts #(
  parameter int VDST_W = 8
) (
  input logic              CLK,
  input logic              rst_n,
  input logic              sb_valid,
  input logic              sb_ready,
  input logic [VDST_W-1:0] sb_vdst,
  input logic              wb_valid,
  input logic              wb_ready,
  input logic              weight_en,
  input logic              input_en,
  input logic              pipe_empty,  // no result between accept and output queue
  input logic              vdst_full,
  input logic              vdst_empty,
  input logic              out_push,
  input logic              out_full,
  input logic              out_empty
);

  a_vdst_push: assert property (@(posedge CLK) disable iff (!rst_n) input_en |-> !vdst_full)
    else $error("destination queue pushed while full");

  a_out_push: assert property (@(posedge CLK) disable iff (!rst_n) out_push |-> !out_full)
    else $error("output queue pushed while full, a result was dropped");

  // a result never leaves without its destination
  a_pair_pop: assert property (@(posedge CLK) disable iff (!rst_n)
    (wb_ready && !out_empty) |-> !vdst_empty)
    else $error("output queue popped with the destination queue empty");

  a_wb_ready: assert property (@(posedge CLK) disable iff (!rst_n) wb_valid |-> wb_ready)
    else $error("wb_valid high while wb_ready is low");

  a_weight_idle: assert property (@(posedge CLK) disable iff (!rst_n) weight_en |-> pipe_empty)
    else $error("weight load while results are in flight");

  a_vdst_hold: assert property (@(posedge CLK) disable iff (!rst_n)
    (sb_valid && !sb_ready) |=> $stable(sb_vdst))
    else $error("sb_vdst changed while the request waited for ready");

endmodule

bind gsau_top gsau_asserts #(
  .VDST_W($clog2(VEGGIEREGS))
) u_asserts (
  .CLK       (CLK),
  .rst_n     (rst_n),
  .sb_valid  (sb_valid),
  .sb_ready  (sb_ready),
  .sb_vdst   (sb_vdst),
  .wb_valid  (wb_valid),
  .wb_ready  (wb_ready),
  .weight_en (sa_weight_en),
  .input_en  (sa_input_en),
  .pipe_empty(u_array.in_flight == '0),
  .vdst_full (u_ctrl.vdst_full),
  .vdst_empty(u_ctrl.vdst_empty),
  .out_push  (u_array.u_out_q.push),
  .out_full  (u_array.u_out_q.full),
  .out_empty (u_array.u_out_q.empty)
);

// File: test/gsau_stimulus.txt
# W w0 w1 w2 w3 loads one weight row into row 0, w0 goes to column 0
# I vdst a0 a1 a2 a3 p0 p1 p2 p3 e0 e1 e2 e3 is an input with its expected writeback, all hex
W 01 02 03 04
W 05 06 07 08
W 09 0a 0b 0c
W 0d 0e 0f 10
I 01 01 00 00 00 0000 0000 0000 0000 000d 000e 000f 0010
I 02 00 00 00 01 0000 0000 0000 0000 0001 0002 0003 0004
I 03 01 01 01 01 0000 0000 0000 0000 001c 0020 0024 0028
I 04 01 02 03 04 0000 0000 0000 0000 0032 003c 0046 0050
I 05 01 01 01 01 0100 0200 0300 0400 011c 0220 0324 0428
I 06 ff ff ff ff ffff fff0 8000 0001 1be3 1fd0 a3dc 27d9
I 07 0a 14 1e 28 fff0 0000 1234 abcd 01e4 0258 14f0 aeed
# burst to distinct destinations, longer than the output queue
I 10 02 00 00 00 0000 0000 0000 0000 001a 001c 001e 0020
I 11 00 03 00 00 0000 0000 0000 0000 001b 001e 0021 0024
I 12 00 00 04 00 0000 0000 0000 0000 0014 0018 001c 0020
I 13 00 00 00 05 0000 0000 0000 0000 0005 000a 000f 0014
I 14 01 01 00 00 0001 0001 0001 0001 0017 0019 001b 001d
I 15 00 00 01 01 0010 0020 0030 0040 0016 0028 003a 004c
I 16 02 02 02 02 0000 0000 0000 0000 0038 0040 0048 0050
I 17 03 00 00 01 0000 0000 0000 0000 0028 002c 0030 0034
I 18 00 01 00 02 0000 0000 0000 0000 000b 000e 0011 0014
I 19 01 00 02 00 0000 0000 0000 0000 0017 001a 001d 0020
I 1a 00 00 00 00 beef cafe 0001 ffff beef cafe 0001 ffff
I 1b 04 03 02 01 0000 0000 0000 0000 005a 0064 006e 0078
# second weight set
W 10 20 30 40
W 01 01 01 01
W 00 ff 00 ff
W 02 00 02 00
I 20 01 00 00 00 0000 0000 0000 0000 0002 0000 0002 0000
I 21 00 01 00 00 0000 0000 0000 0000 0000 00ff 0000 00ff
I 22 05 06 07 08 0000 0000 0000 0000 0091 0701 0191 0801
I 23 ff ff ff ff ffff ffff ffff ffff 12ec 1edf 32cc 3ebf

// File: test/gsau_tb.sv
`timescale 1ns/1ns

// drives gsau_top from the stimulus file and scores every writeback in order
module gsau_tb import gsau_pkg::*; ();

  localparam int    VEGGIEREGS = 256;
  localparam int    VDST_DEPTH = 16;
  localparam int    OUT_DEPTH  = 8;
  localparam string STIM_FILE  = "test/gsau_stimulus.txt";

  typedef logic [$clog2(VEGGIEREGS)-1:0] vdst_t;

  // one parsed stimulus line
  typedef struct packed {
    logic      is_weight;
    vdst_t     vdst;
    elem_vec_t vec;       // weight row or activations
    psum_vec_t partials;
    psum_vec_t expected;  // only meaningful for inputs
  } stim_t;

  logic        CLK;
  logic        rst_n;
  logic        sb_valid;
  logic        sb_ready;
  logic        sb_weight;
  vdst_t       sb_vdst;
  elem_vec_t   veg_vdata1;
  psum_vec_t   veg_vdata2;
  logic        wb_ready;
  logic        wb_valid;
  vdst_t       wb_vdst;
  psum_vec_t   wb_psum;

  stim_t       stim_q[$];
  stim_t       exp_q[$];        // inputs still owed a writeback, oldest first
  int          n_inputs    = 0;
  int          wb_count    = 0;
  int          cycles      = 0;
  int          cycle_limit = 0;  // set once the file length is known
  logic        stall_on    = 1'b0;
  logic [31:0] lfsr;

  gsau_top #(
    .VEGGIEREGS(VEGGIEREGS),
    .VDST_DEPTH(VDST_DEPTH),
    .OUT_DEPTH (OUT_DEPTH)
  ) DUT (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .sb_valid  (sb_valid),
    .sb_ready  (sb_ready),
    .sb_weight (sb_weight),
    .sb_vdst   (sb_vdst),
    .veg_vdata1(veg_vdata1),
    .veg_vdata2(veg_vdata2),
    .wb_ready  (wb_ready),
    .wb_valid  (wb_valid),
    .wb_vdst   (wb_vdst),
    .wb_psum   (wb_psum)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;  // 4 ns period
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "first error, run stopped");
  endtask

  task automatic check_vdst(input vdst_t got, input vdst_t exp);
    if (got !== exp) abort_run($sformatf("Mismatch wb_vdst: got %h expected %h", got, exp));
  endtask

  task automatic check_psum(input psum_vec_t got, input psum_vec_t exp);
    if (got !== exp) abort_run($sformatf("Mismatch wb_psum: got %h expected %h", got, exp));
  endtask

  // right-shift galois form, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // parse the whole file up front so the timeout can scale with it
  task automatic load_stimulus();
    int               fd;
    int               n;
    byte              tag;
    logic [15:0]      vd;
    logic [15:0]      f [12];
    logic [8*256-1:0] skip;
    stim_t            s;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) abort_run("could not open the stimulus file");
    while (1) begin
      n = $fscanf(fd, " %c", tag);
      if (n != 1) break;  // end of file
      s = '0;
      if (tag == "#") begin
        n = $fgets(skip, fd);  // comment line
      end else if (tag == "W") begin
        n = $fscanf(fd, " %h %h %h %h", f[0], f[1], f[2], f[3]);
        if (n != 4) abort_run("weight line in the stimulus file is short");
        s.is_weight = 1'b1;
        for (int i = 0; i < ARRAY_N; i++) begin
          s.vec[i] = f[i][DATA_W-1:0];
        end
        stim_q.push_back(s);
      end else if (tag == "I") begin
        n = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h %h %h %h", vd,
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
        if (n != 13) abort_run("input line in the stimulus file is short");
        s.vdst = vdst_t'(vd);
        for (int i = 0; i < ARRAY_N; i++) begin
          s.vec[i]      = f[i][DATA_W-1:0];
          s.partials[i] = f[i+4];
          s.expected[i] = f[i+8];
        end
        stim_q.push_back(s);
        n_inputs++;
      end else begin
        abort_run($sformatf("unknown line tag %c in the stimulus file", tag));
      end
    end
    $fclose(fd);
  endtask

  // hold the request until the handshake edge, returns 1 ns after it
  task automatic send_request(input stim_t s);
    sb_valid   = 1'b1;
    sb_weight  = s.is_weight;
    sb_vdst    = s.vdst;
    veg_vdata1 = s.vec;
    veg_vdata2 = s.partials;
    do begin
      @(negedge CLK);
    end while (!sb_ready);
    @(posedge CLK);  // transfer
    #1;
    sb_valid = 1'b0;
  endtask

  task automatic wait_for_drain();
    while (exp_q.size() != 0) begin
      @(posedge CLK);
      #1;
    end
  endtask

  // writeback stalls, two lfsr bits per cycle so about one cycle in four is low
  initial begin
    logic [1:0] pick;
    lfsr     = 32'hdb90;
    wb_ready = 1'b1;
    forever begin
      @(posedge CLK);
      #1;
      if (stall_on) begin
        pick[0]  = lfsr[0];
        lfsr     = lfsr_next(lfsr);
        pick[1]  = lfsr[0];
        lfsr     = lfsr_next(lfsr);
        wb_ready = (pick != 2'b00);
      end
    end
  end

  // outputs are settled by the falling edge, a beat seen here pops on the next rise
  always @(negedge CLK) begin
    stim_t e;
    if (rst_n) begin
      if (sb_ready && !wb_ready) abort_run("sb_ready is high while writeback is stalled");
      if (wb_valid) begin
        if (exp_q.size() == 0) begin
          abort_run("writeback arrived with no input outstanding");
        end else begin
          e = exp_q.pop_front();
          check_vdst(wb_vdst, e.vdst);
          check_psum(wb_psum, e.expected);
          wb_count++;
        end
      end
    end
  end

  initial begin
    forever begin
      @(posedge CLK);
      cycles++;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
        abort_run($sformatf("timeout after %0d cycles with writebacks missing", cycles));
      end
    end
  end

  initial begin
    rst_n      = 1'b0;
    sb_valid   = 1'b0;
    sb_weight  = 1'b0;
    sb_vdst    = '0;
    veg_vdata1 = '0;
    veg_vdata2 = '0;
    load_stimulus();
    cycle_limit = 40 * stim_q.size() + 200;
    repeat (3) @(posedge CLK);
    #1;
    rst_n = 1'b1;
    repeat (3) begin  // idle unit after reset
      @(negedge CLK);
      if (wb_valid !== 1'b0) abort_run("wb_valid is high after reset with nothing issued");
      if (sb_ready !== 1'b1) abort_run("sb_ready is low after reset");
    end
    stall_on = 1'b1;
    @(posedge CLK);
    #1;
    foreach (stim_q[i]) begin
      if (stim_q[i].is_weight) wait_for_drain();  // no weight shift under live data
      else exp_q.push_back(stim_q[i]);
      send_request(stim_q[i]);
    end
    wait_for_drain();
    repeat (2 * sa_lat) @(posedge CLK);  // room for a stray extra beat to show up
    if (wb_count != n_inputs) begin
      abort_run($sformatf("Mismatch writeback count: got %h expected %h", wb_count, n_inputs));
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule
